// ==== build.f ====
+incdir+verification
common/mmio_pkg.sv
mmio/mmio_req_queue.sv
mmio/mmio_mem_port.sv
mmio/mmio_periph_port.sv
mmio/mmio_resp_merge.sv
mmio/mmio_top.sv
verification/mmio_tb.sv

// ==== Bender.yml ====
package:
  name: mmio_router

sources:
  - common/mmio_pkg.sv
  - mmio/mmio_req_queue.sv
  - mmio/mmio_mem_port.sv
  - mmio/mmio_periph_port.sv
  - mmio/mmio_resp_merge.sv
  - mmio/mmio_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/mmio_tb.sv

// ==== verification/mmio_tb_tasks.svh ====
// prints the reason, then ends the run
task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
endtask

task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
        abort_run($sformatf("error at %0t ns: %s is %h, expected %h",
                            $time, what, actual, expected));
endtask

// one request, issued only while a credit is held
task automatic send_request(input logic is_write, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp_rdata);
    int waited;
    waited = 0;
    while (sent - credits_back >= QUEUE_DEPTH) begin   // out of credits
        @(posedge clk);
        #1;
        waited++;
        if (waited > TIMEOUT_CYCLES)
            abort_run("timeout: no credit came back for a new request");
    end
    req_valid_i = 1'b1;
    req_write_i = is_write;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    sent++;
    if (!is_write)
        exp_q.push_back(exp_rdata);        // reads expect data in issue order
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
endtask

// every issued request has returned its credit and read data
task automatic wait_retired();
    int waited;
    waited = 0;
    while (credits_back != sent || exp_q.size() != 0) begin
        @(posedge clk);
        #1;
        waited++;
        if (waited > TIMEOUT_CYCLES)
            abort_run("timeout: outstanding requests did not retire");
    end
endtask

task automatic present_touch(input logic [31:0] xy);
    touch_xy_i    = xy;
    touch_valid_i = 1'b1;                  // one-cycle sample strobe
    @(posedge clk);
    #1;
    touch_valid_i = 1'b0;
    touch_last    = xy;
endtask

task automatic reset_outputs_low();
    compare_value(credit_o, 1'b0, "credit_o after reset");
    compare_value(rsp_valid_o, 1'b0, "rsp_valid_o after reset");
    compare_value({mem_cyc_o, mem_stb_o, mem_we_o}, 3'b000, "bus controls after reset");
    compare_value(spi_start_o, 1'b0, "spi_start_o after reset");
    compare_value(spi_command_o, '0, "spi_command_o after reset");
    compare_value(spi_counter_o, '0, "spi_counter_o after reset");
    compare_value(spi_parameters_o, '0, "spi_parameters_o after reset");
endtask

// ==== verification/mmio_tb.sv ====
`timescale 1ns/1ns

module mmio_tb;

    localparam int QUEUE_DEPTH     = 4;
    localparam int TIMEOUT_CYCLES  = 200;  // limit for every wait loop
    localparam int SPI_BUSY_CYCLES = 6;    // display busy time after a start

    logic        clk = 1'b0;
    logic        nRst;
    logic        req_valid_i, req_write_i;
    logic [31:0] req_addr_i, req_wdata_i;
    logic        credit_o, rsp_valid_o;
    logic [31:0] rsp_data_o;
    logic        mem_cyc_o, mem_stb_o, mem_we_o, mem_ack_i;
    logic [31:0] mem_adr_o, mem_dat_o, mem_dat_i;
    logic [7:0]  spi_command_o;
    logic [3:0]  spi_counter_o;
    logic [31:0] spi_parameters_o;
    logic        spi_start_o, spi_busy_i;
    logic [31:0] touch_xy_i;
    logic        touch_valid_i;

    logic [31:0] mem [2048];               // word-addressed data memory model
    logic [31:0] exp_q [$];                // expected read data with the oldest first
    int          sent, credits_back;       // requests issued and credits seen
    int          mem_accesses, spi_starts;
    logic        slow_ack;                 // long ack delay for the stall test
    logic [31:0] touch_last, kept_addr, kept_data;

    always #4 clk = ~clk;

    mmio_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) UUT (.*);

    // memory acks after 0..5 cycles or after 12 when slow_ack is set
    initial begin
        int delay;
        mem_ack_i = 1'b0;
        mem_dat_i = '0;
        for (int i = 0; i < 2048; i++)
            mem[i] = {i[15:0], ~i[15:0]};  // pattern differs at every address
        forever begin
            @(posedge clk);
            #1;
            if (mem_cyc_o && mem_stb_o) begin
                mem_accesses++;
                delay = slow_ack ? 12 : $urandom_range(5, 0);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                if (mem_we_o)
                    mem[mem_adr_o[10:0]] = mem_dat_o;
                else
                    mem_dat_i = mem[mem_adr_o[10:0]];
                mem_ack_i = 1'b1;          // single-cycle ack
                @(posedge clk);
                #1;
                mem_ack_i = 1'b0;
            end
        end
    end

    // spi display model stays busy for a fixed time after every start
    initial begin
        int busy_left;
        busy_left = 0;
        spi_busy_i = 1'b0;
        forever begin
            @(posedge clk);
            if (spi_start_o) begin
                compare_value(spi_busy_i, 1'b0, "spi_busy_i at spi_start_o");
                spi_starts++;
                busy_left = SPI_BUSY_CYCLES;
            end
            #1;
            spi_busy_i = (busy_left != 0);
            if (busy_left != 0)
                busy_left--;
        end
    end

    // credit counter and in-order read scoreboard
    always @(posedge clk) begin
        if (credit_o) begin
            if (credits_back >= sent)
                abort_run("credit returned with no request outstanding");
            credits_back++;
        end
        if (rsp_valid_o) begin
            if (exp_q.size() == 0)
                abort_run("read data returned with no read outstanding");
            else
                compare_value(rsp_data_o, exp_q.pop_front(), "read data");
        end
    end

    `include "mmio_tb_tasks.svh"

    // reads zero before any sample and the latest presented value after
    task automatic touch_read();
        send_request(1'b0, mmio_pkg::TOUCH_ADDR, '0, 32'h0);
        wait_retired();
        present_touch($urandom());
        present_touch($urandom());
        send_request(1'b0, mmio_pkg::TOUCH_ADDR, '0, touch_last);
        wait_retired();
    endtask

    task automatic memory_round_trip();
        logic [31:0] addr [6];
        logic [31:0] data [6];
        for (int i = 0; i < 6; i++) begin
            addr[i] = (i == 5) ? mmio_pkg::MEM_LIMIT - 1 : i * 331; // last word included
            data[i] = $urandom();
            send_request(1'b1, addr[i], data[i], '0);
        end
        for (int i = 0; i < 6; i++)
            send_request(1'b0, addr[i], '0, data[i]);
        wait_retired();
        kept_addr = addr[2];               // reused by the stall test
        kept_data = data[2];
    endtask

    task automatic spi_programming();
        mmio_pkg::spi_word_u w;
        int starts_before;
        starts_before = spi_starts;
        w.raw = $urandom();
        send_request(1'b1, mmio_pkg::SPI_CMD_ADDR, w.raw, '0);
        wait_retired();
        compare_value(spi_command_o, w.raw[7:0], "spi_command_o");
        compare_value(spi_counter_o, w.raw[11:8], "spi_counter_o");
        compare_value(spi_starts, starts_before, "spi starts after command write");
        send_request(1'b1, mmio_pkg::SPI_PARAM_ADDR, 32'h1357_9bdf, '0);
        wait_retired();
        compare_value(spi_parameters_o, 32'h1357_9bdf, "spi_parameters_o");
        compare_value(spi_starts, starts_before + 1, "spi starts after parameter write");
        // second write arrives while the display is still busy
        send_request(1'b1, mmio_pkg::SPI_PARAM_ADDR, 32'h2468_ace0, '0);
        wait_retired();
        compare_value(spi_parameters_o, 32'h2468_ace0, "spi_parameters_o");
        compare_value(spi_starts, starts_before + 2, "spi starts after second write");
    endtask

    task automatic unmapped_access();
        int mem_before, starts_before;
        mem_before    = mem_accesses;
        starts_before = spi_starts;
        send_request(1'b0, mmio_pkg::MEM_LIMIT, '0, mmio_pkg::BAD_READ_VALUE);
        send_request(1'b0, mmio_pkg::SPI_CMD_ADDR, '0, mmio_pkg::BAD_READ_VALUE); // write only
        send_request(1'b1, 32'h00ab_cdef, $urandom(), '0);
        send_request(1'b1, mmio_pkg::TOUCH_ADDR, $urandom(), '0);               // read only
        wait_retired();
        compare_value(mem_accesses, mem_before, "memory cycles for unmapped requests");
        compare_value(spi_starts, starts_before, "spi starts for unmapped requests");
    endtask

    // slow memory read at the head with peripheral reads piling up behind it
    task automatic ordering_under_stall();
        slow_ack = 1'b1;
        send_request(1'b0, kept_addr, '0, kept_data);
        for (int i = 1; i <= QUEUE_DEPTH; i++) begin   // the last one needs a returned credit
            if (i % 2)
                send_request(1'b0, mmio_pkg::TOUCH_ADDR, '0, touch_last);
            else
                send_request(1'b0, mmio_pkg::MEM_LIMIT + i, '0, mmio_pkg::BAD_READ_VALUE);
        end
        wait_retired();
        slow_ack = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hd9ef_d94e));    // single seed for the run
        nRst          = 1'b0;
        req_valid_i   = 1'b0;
        req_write_i   = 1'b0;
        req_addr_i    = '0;
        req_wdata_i   = '0;
        touch_xy_i    = '0;
        touch_valid_i = 1'b0;
        slow_ack      = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        nRst = 1'b1;
        reset_outputs_low();
        touch_read();
        memory_round_trip();
        spi_programming();
        unmapped_access();
        ordering_under_stall();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== mmio/mmio_top.sv ====
`timescale 1ns/1ns

module mmio_top #(
    parameter int QUEUE_DEPTH = 4 // credits handed to the requester, power of two
) (
    input  logic        clk,
    input  logic        nRst,
    // memory handler request side
    input  logic        req_valid_i,
    input  logic        req_write_i,
    input  logic [31:0] req_addr_i,
    input  logic [31:0] req_wdata_i,
    // memory handler response side
    output logic        credit_o,
    output logic        rsp_valid_o,
    output logic [31:0] rsp_data_o,
    // wishbone-style data memory
    output logic        mem_cyc_o,
    output logic        mem_stb_o,
    output logic        mem_we_o,
    output logic [31:0] mem_adr_o,
    output logic [31:0] mem_dat_o,
    input  logic [31:0] mem_dat_i,
    input  logic        mem_ack_i,
    // spi display controller
    output logic [7:0]  spi_command_o,
    output logic [3:0]  spi_counter_o,
    output logic [31:0] spi_parameters_o,
    output logic        spi_start_o,
    input  logic        spi_busy_i,
    // i2c touch sensor
    input  logic [31:0] touch_xy_i,
    input  logic        touch_valid_i
);

    // queue -> memory path
    logic        mem_req_valid, mem_req_write, mem_req_ready;
    logic [31:0] mem_req_addr, mem_req_wdata;
    // queue -> peripheral path
    logic        per_req_valid, per_req_write, per_req_ready;
    logic [31:0] per_req_wdata;
    mmio_pkg::target_e per_req_tgt;
    // queue -> merge order record
    logic        ord_push;
    mmio_pkg::target_e ord_tgt;
    // paths -> merge
    logic        mem_rsp_valid, mem_rsp_write, mem_rsp_take;
    logic [31:0] mem_rsp_data;
    logic        per_rsp_valid, per_rsp_write, per_rsp_take;
    logic [31:0] per_rsp_data;

    mmio_req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk(clk), .nRst(nRst),
        .req_valid_i(req_valid_i), .req_write_i(req_write_i),
        .req_addr_i(req_addr_i), .req_wdata_i(req_wdata_i),
        .mem_req_ready_i(mem_req_ready), .per_req_ready_i(per_req_ready),
        .mem_req_valid_o(mem_req_valid), .mem_req_write_o(mem_req_write),
        .mem_req_addr_o(mem_req_addr), .mem_req_wdata_o(mem_req_wdata),
        .per_req_valid_o(per_req_valid), .per_req_tgt_o(per_req_tgt),
        .per_req_write_o(per_req_write), .per_req_wdata_o(per_req_wdata),
        .ord_push_o(ord_push), .ord_tgt_o(ord_tgt)
    );

    mmio_mem_port u_mem_port (
        .clk(clk), .nRst(nRst),
        .req_valid_i(mem_req_valid), .req_write_i(mem_req_write),
        .req_addr_i(mem_req_addr), .req_wdata_i(mem_req_wdata),
        .mem_dat_i(mem_dat_i), .mem_ack_i(mem_ack_i), .rsp_take_i(mem_rsp_take),
        .req_ready_o(mem_req_ready),
        .mem_cyc_o(mem_cyc_o), .mem_stb_o(mem_stb_o), .mem_we_o(mem_we_o),
        .mem_adr_o(mem_adr_o), .mem_dat_o(mem_dat_o),
        .rsp_valid_o(mem_rsp_valid), .rsp_data_o(mem_rsp_data), .rsp_write_o(mem_rsp_write)
    );

    mmio_periph_port u_periph_port (
        .clk(clk), .nRst(nRst),
        .req_valid_i(per_req_valid), .req_tgt_i(per_req_tgt),
        .req_write_i(per_req_write), .req_wdata_i(per_req_wdata),
        .spi_busy_i(spi_busy_i), .touch_xy_i(touch_xy_i), .touch_valid_i(touch_valid_i),
        .rsp_take_i(per_rsp_take), .req_ready_o(per_req_ready),
        .spi_command_o(spi_command_o), .spi_counter_o(spi_counter_o),
        .spi_parameters_o(spi_parameters_o), .spi_start_o(spi_start_o),
        .rsp_valid_o(per_rsp_valid), .rsp_data_o(per_rsp_data), .rsp_write_o(per_rsp_write)
    );

    mmio_resp_merge #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_merge (
        .clk(clk), .nRst(nRst),
        .ord_push_i(ord_push), .ord_tgt_i(ord_tgt),
        .mem_rsp_valid_i(mem_rsp_valid), .mem_rsp_data_i(mem_rsp_data),
        .mem_rsp_write_i(mem_rsp_write),
        .per_rsp_valid_i(per_rsp_valid), .per_rsp_data_i(per_rsp_data),
        .per_rsp_write_i(per_rsp_write),
        .mem_rsp_take_o(mem_rsp_take), .per_rsp_take_o(per_rsp_take),
        .credit_o(credit_o), .rsp_valid_o(rsp_valid_o), .rsp_data_o(rsp_data_o)
    );

endmodule

// ==== mmio/mmio_resp_merge.sv ====
`timescale 1ns/1ns

module mmio_resp_merge #(
    parameter int QUEUE_DEPTH = 4 // never more in flight than credits
) (
    input  logic                        clk,
    input  logic                        nRst,
    input  logic                        ord_push_i,
    input  mmio_pkg::target_e           ord_tgt_i,
    input  logic                        mem_rsp_valid_i,
    input  logic [mmio_pkg::DATA_W-1:0] mem_rsp_data_i,
    input  logic                        mem_rsp_write_i,
    input  logic                        per_rsp_valid_i,
    input  logic [mmio_pkg::DATA_W-1:0] per_rsp_data_i,
    input  logic                        per_rsp_write_i,
    output logic                        mem_rsp_take_o,
    output logic                        per_rsp_take_o,
    output logic                        credit_o,
    output logic                        rsp_valid_o,
    output logic [mmio_pkg::DATA_W-1:0] rsp_data_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    mmio_pkg::target_e ord_q [QUEUE_DEPTH]; // dispatch order, oldest at rd_ptr
    logic [PTR_W-1:0]  wr_ptr, rd_ptr;
    logic [PTR_W:0]    count;
    logic head_valid, head_is_mem, retire, rsp_write;

    always_ff @(posedge clk) begin
        if (ord_push_i)
            ord_q[wr_ptr] <= ord_tgt_i;
    end

    assign head_valid  = (count != '0);
    assign head_is_mem = (ord_q[rd_ptr] == mmio_pkg::TGT_MEM); // else periph path

    // only the path at the head may retire
    assign mem_rsp_take_o = head_valid & head_is_mem & mem_rsp_valid_i;
    assign per_rsp_take_o = head_valid & ~head_is_mem & per_rsp_valid_i;
    assign retire         = mem_rsp_take_o | per_rsp_take_o;

    assign rsp_write   = head_is_mem ? mem_rsp_write_i : per_rsp_write_i;
    assign rsp_data_o  = head_is_mem ? mem_rsp_data_i : per_rsp_data_i;
    assign credit_o    = retire;              // one credit per retired request
    assign rsp_valid_o = retire & ~rsp_write; // writes retire silently

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (ord_push_i)
                wr_ptr <= wr_ptr + 1'b1;
            if (retire)
                rd_ptr <= rd_ptr + 1'b1;
            case ({ord_push_i, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== mmio/mmio_periph_port.sv ====
`timescale 1ns/1ns

module mmio_periph_port (
    input  logic                        clk,
    input  logic                        nRst,
    input  logic                        req_valid_i,
    input  mmio_pkg::target_e           req_tgt_i,
    input  logic                        req_write_i,
    input  logic [mmio_pkg::DATA_W-1:0] req_wdata_i,
    input  logic                        spi_busy_i,
    input  logic [mmio_pkg::DATA_W-1:0] touch_xy_i,
    input  logic                        touch_valid_i,
    input  logic                        rsp_take_i,
    output logic                        req_ready_o,
    output logic [7:0]                  spi_command_o,
    output logic [3:0]                  spi_counter_o,
    output logic [mmio_pkg::DATA_W-1:0] spi_parameters_o,
    output logic                        spi_start_o,
    output logic                        rsp_valid_o,
    output logic [mmio_pkg::DATA_W-1:0] rsp_data_o,
    output logic                        rsp_write_o
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_WAIT = 2'd1; // parameter loaded, waiting for spi idle
    localparam logic [1:0] ST_HOLD = 2'd2; // response held until taken

    logic [1:0]                  state;
    logic [mmio_pkg::DATA_W-1:0] touch_q;  // last touch sample
    mmio_pkg::spi_word_u         spi_w;
    logic accept, is_spi_cmd, is_spi_param, is_touch, start_now;

    assign spi_w = req_wdata_i;

    // spi reads and touch writes fall through as unmapped
    assign is_spi_cmd   = req_write_i  && (req_tgt_i == mmio_pkg::TGT_SPI_CMD);
    assign is_spi_param = req_write_i  && (req_tgt_i == mmio_pkg::TGT_SPI_PARAM);
    assign is_touch     = !req_write_i && (req_tgt_i == mmio_pkg::TGT_TOUCH);

    assign req_ready_o = (state == ST_IDLE);
    assign accept      = req_valid_i & req_ready_o;

    // start and respond in the first cycle the spi is idle
    assign start_now   = (state == ST_WAIT) & ~spi_busy_i;
    assign spi_start_o = start_now;
    assign rsp_valid_o = (state == ST_HOLD) | start_now;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state            <= ST_IDLE;
            spi_command_o    <= '0;
            spi_counter_o    <= '0;
            spi_parameters_o <= '0;
            touch_q          <= '0;      // reads zero until a sample arrives
        end else begin
            if (touch_valid_i)
                touch_q <= touch_xy_i;
            case (state)
                ST_IDLE: if (accept) begin
                    if (is_spi_cmd) begin
                        spi_command_o <= spi_w.cmd.command;
                        spi_counter_o <= spi_w.cmd.counter;
                    end
                    if (is_spi_param) begin
                        spi_parameters_o <= spi_w.raw;
                        state <= ST_WAIT;
                    end else begin
                        state <= ST_HOLD; // everything else answers next cycle
                    end
                end
                ST_WAIT: if (start_now)
                    state <= rsp_take_i ? ST_IDLE : ST_HOLD;
                ST_HOLD: if (rsp_take_i)
                    state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_write_o <= req_write_i;
            if (is_touch)
                rsp_data_o <= touch_q;
            else if (req_write_i)
                rsp_data_o <= '0;        // writes carry no data
            else
                rsp_data_o <= mmio_pkg::BAD_READ_VALUE; // unmapped or spi read
        end
    end

endmodule

// ==== mmio/mmio_mem_port.sv ====
`timescale 1ns/1ns

module mmio_mem_port (
    input  logic                        clk,
    input  logic                        nRst,
    input  logic                        req_valid_i,
    input  logic                        req_write_i,
    input  logic [mmio_pkg::DATA_W-1:0] req_addr_i,
    input  logic [mmio_pkg::DATA_W-1:0] req_wdata_i,
    input  logic [mmio_pkg::DATA_W-1:0] mem_dat_i,
    input  logic                        mem_ack_i,
    input  logic                        rsp_take_i,
    output logic                        req_ready_o,
    output logic                        mem_cyc_o,
    output logic                        mem_stb_o,
    output logic                        mem_we_o,
    output logic [mmio_pkg::DATA_W-1:0] mem_adr_o,
    output logic [mmio_pkg::DATA_W-1:0] mem_dat_o,
    output logic                        rsp_valid_o,
    output logic [mmio_pkg::DATA_W-1:0] rsp_data_o,
    output logic                        rsp_write_o
);

    localparam logic [1:0] ST_IDLE = 2'd0; // waiting for a request
    localparam logic [1:0] ST_BUS  = 2'd1; // bus cycle open until ack
    localparam logic [1:0] ST_HOLD = 2'd2; // response held until merge takes it

    logic [1:0] state, state_nxt;
    logic       we_q;                       // direction of the current access

    assign req_ready_o = (state == ST_IDLE);
    assign mem_cyc_o   = (state == ST_BUS);
    assign mem_stb_o   = (state == ST_BUS); // stb follows cyc for a single access
    assign mem_we_o    = (state == ST_BUS) & we_q;
    assign rsp_valid_o = (state == ST_HOLD);
    assign rsp_write_o = we_q;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (req_valid_i) state_nxt = ST_BUS;
            ST_BUS:  if (mem_ack_i)   state_nxt = ST_HOLD;
            ST_HOLD: if (rsp_take_i)  state_nxt = ST_IDLE;
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state <= ST_IDLE;
            we_q  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (req_valid_i && req_ready_o)
                we_q <= req_write_i;
        end
    end

    // bus address and write data latched on accept, read data captured on ack
    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            mem_adr_o <= req_addr_i;
            mem_dat_o <= req_wdata_i;
        end
        if (state == ST_BUS && mem_ack_i)
            rsp_data_o <= mem_dat_i;       // for writes this is ignored
    end

endmodule

// ==== mmio/mmio_req_queue.sv ====
`timescale 1ns/1ns

module mmio_req_queue #(
    parameter int QUEUE_DEPTH = 4 // one slot per credit
) (
    input  logic                          clk,
    input  logic                          nRst,
    input  logic                          req_valid_i,
    input  logic                          req_write_i,
    input  logic [mmio_pkg::DATA_W-1:0]   req_addr_i,
    input  logic [mmio_pkg::DATA_W-1:0]   req_wdata_i,
    input  logic                          mem_req_ready_i,
    input  logic                          per_req_ready_i,
    output logic                          mem_req_valid_o,
    output logic                          mem_req_write_o,
    output logic [mmio_pkg::DATA_W-1:0]   mem_req_addr_o,
    output logic [mmio_pkg::DATA_W-1:0]   mem_req_wdata_o,
    output logic                          per_req_valid_o,
    output mmio_pkg::target_e             per_req_tgt_o,
    output logic                          per_req_write_o,
    output logic [mmio_pkg::DATA_W-1:0]   per_req_wdata_o,
    output logic                          ord_push_o,
    output mmio_pkg::target_e             ord_tgt_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    // entry storage
    logic                        q_write [QUEUE_DEPTH];
    logic [mmio_pkg::DATA_W-1:0] q_addr  [QUEUE_DEPTH];
    logic [mmio_pkg::DATA_W-1:0] q_wdata [QUEUE_DEPTH];
    mmio_pkg::target_e           q_tgt   [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0]   count;             // needs one extra bit for full
    mmio_pkg::target_e in_tgt, head_tgt;
    logic head_valid, head_is_mem, pop;

    // address decode of the incoming request
    always_comb begin
        if (req_addr_i < mmio_pkg::MEM_LIMIT)
            in_tgt = mmio_pkg::TGT_MEM;
        else if (req_addr_i == mmio_pkg::SPI_CMD_ADDR)
            in_tgt = mmio_pkg::TGT_SPI_CMD;
        else if (req_addr_i == mmio_pkg::SPI_PARAM_ADDR)
            in_tgt = mmio_pkg::TGT_SPI_PARAM;
        else if (req_addr_i == mmio_pkg::TOUCH_ADDR)
            in_tgt = mmio_pkg::TGT_TOUCH;
        else
            in_tgt = mmio_pkg::TGT_NONE;   // unmapped so the periph port answers it
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin             // credits guarantee a free slot
            q_write[wr_ptr] <= req_write_i;
            q_addr[wr_ptr]  <= req_addr_i;
            q_wdata[wr_ptr] <= req_wdata_i;
            q_tgt[wr_ptr]   <= in_tgt;
        end
    end

    assign head_valid  = (count != '0);
    assign head_tgt    = q_tgt[rd_ptr];
    assign head_is_mem = (head_tgt == mmio_pkg::TGT_MEM);

    // head goes to exactly one path
    assign mem_req_valid_o = head_valid & head_is_mem;
    assign per_req_valid_o = head_valid & ~head_is_mem;
    assign pop = (mem_req_valid_o & mem_req_ready_i) | (per_req_valid_o & per_req_ready_i);

    assign mem_req_write_o = q_write[rd_ptr];
    assign mem_req_addr_o  = q_addr[rd_ptr];
    assign mem_req_wdata_o = q_wdata[rd_ptr];
    assign per_req_tgt_o   = head_tgt;
    assign per_req_write_o = q_write[rd_ptr];
    assign per_req_wdata_o = q_wdata[rd_ptr];

    // record dispatch order for the merge
    assign ord_push_o = pop;
    assign ord_tgt_o  = head_tgt;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid_i)
                wr_ptr <= wr_ptr + 1'b1;   // wraps since depth is a power of two
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({req_valid_i, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // none or both
            endcase
        end
    end

endmodule

// ==== common/mmio_pkg.sv ====
package mmio_pkg;

    // bus widths
    localparam int DATA_W = 32;                          // data and address width

    // address map
    localparam logic [DATA_W-1:0] MEM_LIMIT      = 32'd2048;   // first non-memory address
    localparam logic [DATA_W-1:0] SPI_CMD_ADDR   = 32'd121212; // spi command + counter
    localparam logic [DATA_W-1:0] SPI_PARAM_ADDR = 32'd333333; // spi parameter, starts transfer
    localparam logic [DATA_W-1:0] TOUCH_ADDR     = 32'd923923; // latest touch coordinate

    localparam logic [DATA_W-1:0] BAD_READ_VALUE = 32'hDEADBEEF; // returned for unmapped reads

    // where a request is routed after decode
    typedef enum logic [2:0] {
        TGT_MEM,       // data memory, wishbone path
        TGT_SPI_CMD,   // spi command register
        TGT_SPI_PARAM, // spi parameter register
        TGT_TOUCH,     // touch sample
        TGT_NONE       // unmapped, answered by periph port
    } target_e;

    // spi data word, seen as command fields or as a raw parameter
    typedef union packed {
        struct packed {
            logic [19:0] reserved; // unused upper bits
            logic [3:0]  counter;  // bits 11:8
            logic [7:0]  command;  // low byte
        } cmd;
        logic [DATA_W-1:0] raw;    // whole word, parameter view
    } spi_word_u;

endpackage
